/* isaPkg.sv */
/*
 * Instruction set definitions for the integer pipeline
 *   data and register-address widths, register count
 *   opcode and function codes of the supported instructions
 *   R-type and I-type field layouts, joined in one instruction union
 *   ALU operation type
 */
`default_nettype none

package isaPkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } iFields_t;

    // one fetched word, read as R-type or I-type
    typedef union packed {
        rFields_t          r;
        iFields_t          i;
        logic [DATA_W-1:0] raw;
    } instrWord_u;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOp_e;

endpackage

`default_nettype wire

/* pipePkg.sv */
/*
 * Pipeline definitions
 *   decoded control word
 *   decode/execute, execute/memory and memory/writeback registers
 *   forwarding select type
 *   writeback port
 */
`default_nettype none

package pipePkg;

    typedef struct packed {
        isaPkg::aluOp_e aluOp;
        logic           aluSrcImm;
        logic           memRead;
        logic           memWrite;
        logic           memToReg;
        logic           regWrite;
    } ctrl_t;

    // rs and rt hold only the sources the instruction really reads, zero otherwise
    typedef struct packed {
        logic                          valid;
        ctrl_t                         ctrl;
        logic [isaPkg::REG_ADDR_W-1:0] rs;
        logic [isaPkg::REG_ADDR_W-1:0] rt;
        logic [isaPkg::REG_ADDR_W-1:0] dst;
        logic [isaPkg::DATA_W-1:0]     opA;
        logic [isaPkg::DATA_W-1:0]     opB;
        logic [isaPkg::DATA_W-1:0]     imm;
    } idEx_t;

    typedef struct packed {
        logic                          valid;
        ctrl_t                         ctrl;
        logic [isaPkg::REG_ADDR_W-1:0] dst;
        logic [isaPkg::DATA_W-1:0]     aluResult;
        logic [isaPkg::DATA_W-1:0]     storeData;
    } exMem_t;

    typedef struct packed {
        logic                          valid;
        logic                          memToReg;
        logic                          regWrite;
        logic [isaPkg::REG_ADDR_W-1:0] dst;
        logic [isaPkg::DATA_W-1:0]     aluResult;
        logic [isaPkg::DATA_W-1:0]     loadData;
    } memWb_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwdSel_e;

    typedef struct packed {
        logic                          valid;
        logic [isaPkg::REG_ADDR_W-1:0] addr;
        logic [isaPkg::DATA_W-1:0]     data;
    } wbPort_t;

endpackage

`default_nettype wire

/* registerFile.sv */
/*
 * General purpose register file
 *   32 words, register 0 reads as zero
 *   two combinational read ports with write-through bypass
 */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [isaPkg::REG_ADDR_W-1:0] raddrA,
    input  logic [isaPkg::REG_ADDR_W-1:0] raddrB,
    input  pipePkg::wbPort_t              wr,
    output logic [isaPkg::DATA_W-1:0]     rdataA,
    output logic [isaPkg::DATA_W-1:0]     rdataB
);

    logic [isaPkg::DATA_W-1:0] regs [isaPkg::NUM_REGS];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int k = 0; k < isaPkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.valid && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // same-cycle write wins over the stored word
    function automatic logic [isaPkg::DATA_W-1:0] readPort(
        input logic [isaPkg::REG_ADDR_W-1:0] addr,
        input logic [isaPkg::DATA_W-1:0]     stored,
        input pipePkg::wbPort_t              wrPort
    );
        if (addr == '0) begin
            return '0;
        end
        if (wrPort.valid && wrPort.addr == addr) begin
            return wrPort.data;
        end
        return stored;
    endfunction

    assign rdataA = readPort(raddrA, regs[raddrA], wr);
    assign rdataB = readPort(raddrB, regs[raddrB], wr);

    // writeback filters out register 0 before it gets here
    noWriteToZero: assert property (@(posedge clk) disable iff (!reset_n)
        wr.valid |-> (wr.addr != '0));

endmodule

`default_nettype wire

/* hazardForwardUnit.sv */
/*
 * Hazard and forwarding unit
 *   load-use stall detection against the decode/execute slot
 *   operand forwarding selects, execute/memory before writeback
 */
`timescale 1ns/1ps
`default_nettype none

module hazardForwardUnit (
    input  logic [isaPkg::REG_ADDR_W-1:0] srcRs,
    input  logic [isaPkg::REG_ADDR_W-1:0] srcRt,
    input  pipePkg::idEx_t                idEx,
    input  pipePkg::exMem_t               exMem,
    input  pipePkg::memWb_t               memWb,
    output logic                          stall,
    output pipePkg::fwdSel_e              fwdA,
    output pipePkg::fwdSel_e              fwdB
);

    function automatic pipePkg::fwdSel_e pickSource(
        input logic [isaPkg::REG_ADDR_W-1:0] src,
        input pipePkg::exMem_t               em,
        input pipePkg::memWb_t               mw
    );
        if (src == '0) begin
            return pipePkg::FWD_NONE;
        end
        if (em.valid && em.ctrl.regWrite && em.dst == src) begin
            return pipePkg::FWD_MEM;
        end
        if (mw.valid && mw.regWrite && mw.dst == src) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_NONE;
    endfunction

    assign stall = idEx.valid && idEx.ctrl.memRead && (idEx.dst != '0)
                   && ((idEx.dst == srcRs) || (idEx.dst == srcRt));

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

    // a load result in execute/memory is never needed, the stall a cycle earlier saw to it
    always_comb begin
        assert final (!(exMem.valid && exMem.ctrl.memRead
                        && (fwdA == pipePkg::FWD_MEM || fwdB == pipePkg::FWD_MEM)));
    end

endmodule

`default_nettype wire

/* decodeStage.sv */
/*
 * Fetch/decode register and decode stage
 *   instruction acceptance on the valid/ready stream
 *   decoder into the control word, unknown words become bubbles
 *   register read and the decode/execute register
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [isaPkg::DATA_W-1:0]     instr,
    input  logic                          instrValid,
    input  logic                          stall,
    input  pipePkg::wbPort_t              wr,
    output logic                          instrReady,
    output logic [isaPkg::REG_ADDR_W-1:0] srcRs,
    output logic [isaPkg::REG_ADDR_W-1:0] srcRt,
    output pipePkg::idEx_t                idEx
);

    logic                      ifIdValid;
    isaPkg::instrWord_u        ifIdInstr;
    pipePkg::ctrl_t            ctrlRaw;
    pipePkg::ctrl_t            ctrl;
    pipePkg::idEx_t            idExNext;
    logic                      known;
    logic                      usesRt;
    logic                      regDstRd;
    logic                      slotValid;
    logic [isaPkg::DATA_W-1:0] rdataA;
    logic [isaPkg::DATA_W-1:0] rdataB;

    assign instrReady = ~stall;

    // hold while stalled, otherwise take whatever the stream offers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            ifIdValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) begin
            ifIdInstr.raw <= instr;
        end
    end

    always_comb begin
        ctrlRaw  = '0;
        known    = 1'b0;
        usesRt   = 1'b0;
        regDstRd = 1'b0;
        case (ifIdInstr.r.opcode)
            isaPkg::OP_RTYPE: begin
                known            = 1'b1;
                usesRt           = 1'b1;
                regDstRd         = 1'b1;
                ctrlRaw.regWrite = 1'b1;
                case (ifIdInstr.r.funct)
                    isaPkg::FN_ADD: ctrlRaw.aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUB: ctrlRaw.aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND: ctrlRaw.aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:  ctrlRaw.aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_SLT: ctrlRaw.aluOp = isaPkg::ALU_SLT;
                    default:        known = 1'b0;
                endcase
            end
            isaPkg::OP_ADDI: begin
                known             = 1'b1;
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.regWrite  = 1'b1;
            end
            isaPkg::OP_LW: begin
                known             = 1'b1;
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.memRead   = 1'b1;
                ctrlRaw.memToReg  = 1'b1;
                ctrlRaw.regWrite  = 1'b1;
            end
            isaPkg::OP_SW: begin
                known             = 1'b1;
                usesRt            = 1'b1;
                ctrlRaw.aluSrcImm = 1'b1;
                ctrlRaw.memWrite  = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign slotValid = ifIdValid && known;

    always_comb begin
        if (slotValid) begin
            ctrl = ctrlRaw;
        end else begin
            ctrl = '0;
        end
    end

    // unused sources read as r0 so they never match a hazard
    assign srcRs = slotValid ? ifIdInstr.r.rs : '0;
    assign srcRt = (slotValid && usesRt) ? ifIdInstr.r.rt : '0;

    registerFile u_registerFile (
        .clk     (clk),
        .reset_n (reset_n),
        .raddrA  (ifIdInstr.r.rs),
        .raddrB  (ifIdInstr.r.rt),
        .wr      (wr),
        .rdataA  (rdataA),
        .rdataB  (rdataB)
    );

    always_comb begin
        idExNext.valid = slotValid;
        idExNext.ctrl  = ctrl;
        idExNext.rs    = srcRs;
        idExNext.rt    = srcRt;
        if (!ctrl.regWrite) begin
            idExNext.dst = '0;
        end else if (regDstRd) begin
            idExNext.dst = ifIdInstr.r.rd;
        end else begin
            idExNext.dst = ifIdInstr.i.rt;
        end
        idExNext.opA = rdataA;
        idExNext.opB = rdataB;
        idExNext.imm = {{(isaPkg::DATA_W - 16){ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm};
    end

    // a stall sends a bubble down while fetch/decode holds
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idEx <= '0;
        end else if (stall) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

`default_nettype wire

/* executeStage.sv */
/*
 * Execute stage
 *   operand forwarding from execute/memory and writeback
 *   immediate select and ALU
 *   execute/memory register
 */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             reset_n,
    input  pipePkg::idEx_t   idEx,
    input  pipePkg::fwdSel_e fwdA,
    input  pipePkg::fwdSel_e fwdB,
    input  pipePkg::wbPort_t wbFwd,
    output pipePkg::exMem_t  exMem
);

    logic [isaPkg::DATA_W-1:0] opA;
    logic [isaPkg::DATA_W-1:0] fwdBVal;
    logic [isaPkg::DATA_W-1:0] opB;
    logic [isaPkg::DATA_W-1:0] aluResult;

    function automatic logic [isaPkg::DATA_W-1:0] pickOperand(
        input pipePkg::fwdSel_e          sel,
        input logic [isaPkg::DATA_W-1:0] regVal,
        input logic [isaPkg::DATA_W-1:0] memVal,
        input logic [isaPkg::DATA_W-1:0] wbVal
    );
        case (sel)
            pipePkg::FWD_MEM: return memVal;
            pipePkg::FWD_WB:  return wbVal;
            default:          return regVal;
        endcase
    endfunction

    assign opA     = pickOperand(fwdA, idEx.opA, exMem.aluResult, wbFwd.data);
    assign fwdBVal = pickOperand(fwdB, idEx.opB, exMem.aluResult, wbFwd.data);
    assign opB     = idEx.ctrl.aluSrcImm ? idEx.imm : fwdBVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            isaPkg::ALU_ADD: aluResult = opA + opB;
            isaPkg::ALU_SUB: aluResult = opA - opB;
            isaPkg::ALU_AND: aluResult = opA & opB;
            isaPkg::ALU_OR:  aluResult = opA | opB;
            isaPkg::ALU_SLT: begin
                aluResult = {{(isaPkg::DATA_W - 1){1'b0}}, $signed(opA) < $signed(opB)};
            end
            default:         aluResult = opA + opB;
        endcase
    end

    // store data takes the forwarded rt value, not the stale register read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.dst       <= idEx.dst;
            exMem.aluResult <= aluResult;
            exMem.storeData <= fwdBVal;
        end
    end

endmodule

`default_nettype wire

/* memoryStage.sv */
/*
 * Memory stage
 *   word-addressed data memory, combinational read
 *   memory/writeback register
 *   writeback port for the register file and the outside
 */
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic             clk,
    input  logic             reset_n,
    input  pipePkg::exMem_t  exMem,
    output pipePkg::memWb_t  memWb,
    output pipePkg::wbPort_t wb
);

    // depth is taken as a power of two, so the slice wraps modulo the depth
    localparam int IDX_W = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    logic [isaPkg::DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [IDX_W-1:0]          idx;
    logic [isaPkg::DATA_W-1:0] rdata;

    assign idx   = exMem.aluResult[IDX_W+1:2];
    assign rdata = dmem[idx];

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[idx] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            memWb <= '0;
        end else begin
            memWb.valid     <= exMem.valid;
            memWb.memToReg  <= exMem.ctrl.memToReg;
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.dst       <= exMem.dst;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= exMem.ctrl.memRead ? rdata : '0;
        end
    end

    assign wb.valid = memWb.valid && memWb.regWrite && (memWb.dst != '0);
    assign wb.addr  = memWb.dst;
    assign wb.data  = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    // decode never builds a slot that both loads and stores
    noLoadStore: assert property (@(posedge clk) disable iff (!reset_n)
        exMem.valid |-> !(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

`default_nettype wire

/* mipsPipe.sv */
/*
 * Five-stage integer pipeline top level
 *   decode, execute and memory stages
 *   shared hazard and forwarding unit
 */
`timescale 1ns/1ps
`default_nettype none

module mipsPipe #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [isaPkg::DATA_W-1:0] instr,
    input  logic                      instrValid,
    output logic                      instrReady,
    output pipePkg::wbPort_t          wb
);

    logic [isaPkg::REG_ADDR_W-1:0] srcRs;
    logic [isaPkg::REG_ADDR_W-1:0] srcRt;
    logic                          stall;
    pipePkg::idEx_t                idEx;
    pipePkg::exMem_t               exMem;
    pipePkg::memWb_t               memWb;
    pipePkg::fwdSel_e              fwdA;
    pipePkg::fwdSel_e              fwdB;

    decodeStage u_decodeStage (
        .clk        (clk),
        .reset_n    (reset_n),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .wr         (wb),
        .instrReady (instrReady),
        .srcRs      (srcRs),
        .srcRt      (srcRt),
        .idEx       (idEx)
    );

    hazardForwardUnit u_hazardForwardUnit (
        .srcRs (srcRs),
        .srcRt (srcRt),
        .idEx  (idEx),
        .exMem (exMem),
        .memWb (memWb),
        .stall (stall),
        .fwdA  (fwdA),
        .fwdB  (fwdB)
    );

    executeStage u_executeStage (
        .clk     (clk),
        .reset_n (reset_n),
        .idEx    (idEx),
        .fwdA    (fwdA),
        .fwdB    (fwdB),
        .wbFwd   (wb),
        .exMem   (exMem)
    );

    memoryStage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_memoryStage (
        .clk     (clk),
        .reset_n (reset_n),
        .exMem   (exMem),
        .memWb   (memWb),
        .wb      (wb)
    );

endmodule

`default_nettype wire

/* tb_mipsPipe.sv */
/*
 * Testbench for the five-stage integer pipeline
 *   clock, reset, valid/ready instruction driver
 *   architectural reference model with expected writeback queue
 *   concurrent assertions on writeback, reset and load-use stall
 *   directed tests, random stream, watchdog and report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mipsPipe;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DMEM_DEPTH   = 64;
    localparam int          IDX_W        = $clog2(DMEM_DEPTH);
    localparam logic [31:0] SEED         = 32'h5bad;
    localparam int          NUM_RANDOM   = 200;
    localparam int          MAX_GAP      = 3;
    localparam int          INSTR_BUDGET = 512;
    localparam int          DRAIN_CYCLES = 16;
    localparam int          WATCHDOG_NS  = INSTR_BUDGET * (MAX_GAP + 8) * CLK_PERIOD;

    logic             clk;
    logic             reset_n;
    logic [31:0]      instr;
    logic             instrValid;
    logic             instrReady;
    pipePkg::wbPort_t wb;

    // reference model state
    logic [31:0]      modelRegs [32];
    logic [31:0]      modelMem [DMEM_DEPTH];
    pipePkg::wbPort_t expQ [$];
    pipePkg::wbPort_t expHead;
    int               expCount;
    logic             expectStall;
    logic [4:0]       pendingLoad;

    string testName;
    int    errorsAtStart;
    int    testsRun;
    int    testsFailed;
    int    resetErrors;
    int    readyErrors;
    int    stallErrors;
    int    wbErrors;
    int    flowErrors;

    mipsPipe #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mipsPipe (
        .clk        (clk),
        .reset_n    (reset_n),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .wb         (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input int rd,
                                            input int rs, input int rt);
        return {isaPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input int rt,
                                            input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // does the word read register r as a source
    function automatic logic usesSource(input logic [31:0] word, input logic [4:0] r);
        logic [5:0] op;
        op = word[31:26];
        if (r == 5'd0) begin
            return 1'b0;
        end
        if (word[25:21] == r) begin
            return 1'b1;
        end
        if ((op == isaPkg::OP_RTYPE || op == isaPkg::OP_SW) && word[20:16] == r) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // fill value differs for every word index
    function automatic int fillImmediate(input int idx);
        return (idx * 977 + 2652) % 65536;
    endfunction

    function automatic int errorTotal();
        return resetErrors + readyErrors + stallErrors + wbErrors + flowErrors;
    endfunction

    task automatic applyModel(input logic [31:0] word);
        logic [5:0]       op;
        logic [5:0]       fn;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [4:0]       dst;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      imm;
        logic [31:0]      addr;
        logic [31:0]      wordIdx;
        logic [31:0]      result;
        logic             writes;
        pipePkg::wbPort_t entry;
        op      = word[31:26];
        rs      = word[25:21];
        rt      = word[20:16];
        fn      = word[5:0];
        a       = modelRegs[rs];
        b       = modelRegs[rt];
        imm     = {{16{word[15]}}, word[15:0]};
        addr    = a + imm;
        wordIdx = (addr >> 2) % DMEM_DEPTH;
        result  = '0;
        writes  = 1'b0;
        dst     = rt;
        case (op)
            isaPkg::OP_RTYPE: begin
                writes = 1'b1;
                dst    = word[15:11];
                case (fn)
                    isaPkg::FN_ADD: result = a + b;
                    isaPkg::FN_SUB: result = a - b;
                    isaPkg::FN_AND: result = a & b;
                    isaPkg::FN_OR:  result = a | b;
                    isaPkg::FN_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:        writes = 1'b0;
                endcase
            end
            isaPkg::OP_ADDI: begin
                writes = 1'b1;
                result = a + imm;
            end
            isaPkg::OP_LW: begin
                writes = 1'b1;
                result = modelMem[wordIdx[IDX_W-1:0]];
            end
            isaPkg::OP_SW: begin
                modelMem[wordIdx[IDX_W-1:0]] = b;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
        if (writes && dst != 5'd0) begin
            modelRegs[dst] = result;
            entry.valid    = 1'b1;
            entry.addr     = dst;
            entry.data     = result;
            expQ.push_back(entry);
        end
    endtask

    // model follows the stream in program order at each acceptance
    always @(posedge clk) begin
        if (!reset_n) begin
            for (int k = 0; k < 32; k++) begin
                modelRegs[k] = '0;
            end
            expQ.delete();
            expectStall = 1'b0;
            pendingLoad = '0;
        end else begin
            if (wb.valid && expQ.size() > 0) begin
                void'(expQ.pop_front());
            end
            if (instrReady && instrValid) begin
                expectStall = usesSource(instr, pendingLoad);
                pendingLoad = (instr[31:26] == isaPkg::OP_LW) ? instr[20:16] : 5'd0;
                applyModel(instr);
            end else if (instrReady) begin
                // a bubble enters fetch/decode, the load moves on alone
                expectStall = 1'b0;
                pendingLoad = '0;
            end else begin
                expectStall = 1'b0;
            end
        end
        expCount = expQ.size();
        if (expCount > 0) begin
            expHead = expQ[0];
        end else begin
            expHead = '0;
        end
    end

    resetState: assert property (@(posedge clk)
        (!reset_n || $rose(reset_n)) |-> (!wb.valid && instrReady))
    else begin
        $display("error reset: wb.valid/instrReady expected 0/1, got %b/%b",
                 $sampled(wb.valid), $sampled(instrReady));
        resetErrors = resetErrors + 1;
    end

    readyMatch: assert property (@(posedge clk) disable iff (!reset_n)
        instrReady == !expectStall)
    else begin
        $display("error %s: instrReady expected %b, got %b",
                 testName, !$sampled(expectStall), $sampled(instrReady));
        readyErrors = readyErrors + 1;
    end

    stallOneCycle: assert property (@(posedge clk) disable iff (!reset_n)
        !instrReady |=> instrReady)
    else begin
        $display("instrReady stayed low for more than one cycle in test %s", testName);
        stallErrors = stallErrors + 1;
    end

    wbMatch: assert property (@(posedge clk) disable iff (!reset_n)
        wb.valid |-> (expCount > 0 && wb.addr == expHead.addr && wb.data == expHead.data))
    else begin
        if ($sampled(expCount) == 0) begin
            $display("unexpected writeback to r%0d in test %s, nothing was pending",
                     $sampled(wb.addr), testName);
        end else begin
            $display("error %s: writeback expected r%0d=%h, got r%0d=%h", testName,
                     $sampled(expHead.addr), $sampled(expHead.data),
                     $sampled(wb.addr), $sampled(wb.data));
        end
        wbErrors = wbErrors + 1;
    end

    // holds the word until the DUT takes it
    task automatic issue(input logic [31:0] word);
        instr      <= word;
        instrValid <= 1'b1;
        @(posedge clk);
        while (!instrReady) begin
            @(posedge clk);
        end
    endtask

    task automatic idle(input int cycles);
        instrValid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorTotal();
    endtask

    task automatic finishTest();
        instrValid <= 1'b0;
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            if (expQ.size() == 0) begin
                break;
            end
        end
        drained: assert (expQ.size() == 0)
        else begin
            $display("test %s: %0d expected writebacks never appeared", testName, expQ.size());
            flowErrors = flowErrors + 1;
        end
        testsRun = testsRun + 1;
        if (errorTotal() == errorsAtStart) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed = testsFailed + 1;
            $display("test %s: failed, %0d errors", testName, errorTotal() - errorsAtStart);
        end
        @(posedge clk);
    endtask

    task automatic rtypeForwarding();
        startTest("rtype_fwd");
        issue(encodeI(isaPkg::OP_ADDI, 1, 0, 'h1234));
        issue(encodeI(isaPkg::OP_ADDI, 2, 0, -77));
        // r2 from execute/memory, r1 from writeback
        issue(encodeR(isaPkg::FN_ADD, 3, 1, 2));
        issue(encodeR(isaPkg::FN_SUB, 4, 3, 1));
        issue(encodeR(isaPkg::FN_AND, 5, 4, 3));
        issue(encodeR(isaPkg::FN_OR, 6, 5, 4));
        issue(encodeR(isaPkg::FN_SLT, 7, 2, 1));
        issue(encodeR(isaPkg::FN_SLT, 8, 1, 2));
        issue(encodeR(isaPkg::FN_SUB, 9, 8, 7));
        issue(encodeR(isaPkg::FN_SLT, 10, 9, 8));
        // same destination twice in flight, the newer one must win
        issue(encodeR(isaPkg::FN_ADD, 12, 1, 1));
        issue(encodeR(isaPkg::FN_ADD, 12, 12, 1));
        issue(encodeR(isaPkg::FN_ADD, 13, 12, 12));
        issue(encodeR(isaPkg::FN_OR, 11, 9, 6));
        finishTest();
    endtask

    task automatic addiAndZero();
        startTest("addi_r0");
        issue(encodeI(isaPkg::OP_ADDI, 10, 0, -1));
        issue(encodeI(isaPkg::OP_ADDI, 11, 10, -32768));
        issue(encodeI(isaPkg::OP_ADDI, 12, 11, 32767));
        issue(encodeI(isaPkg::OP_ADDI, 15, 0, -32768));
        issue(encodeI(isaPkg::OP_ADDI, 0, 1, 5));
        issue(encodeR(isaPkg::FN_ADD, 13, 0, 0));
        issue(encodeR(isaPkg::FN_OR, 14, 0, 10));
        finishTest();
    endtask

    task automatic memoryAliasing();
        startTest("mem_alias");
        for (int k = 0; k < DMEM_DEPTH; k++) begin
            issue(encodeI(isaPkg::OP_ADDI, 1, 0, fillImmediate(k)));
            issue(encodeI(isaPkg::OP_SW, 1, 0, k * 4));
        end
        issue(encodeI(isaPkg::OP_ADDI, 20, 0, 16));
        issue(encodeI(isaPkg::OP_ADDI, 21, 0, -1234));
        issue(encodeI(isaPkg::OP_SW, 21, 20, 4));
        issue(encodeI(isaPkg::OP_LW, 22, 20, 4));
        issue(encodeI(isaPkg::OP_LW, 23, 20, 4 + DMEM_DEPTH * 4));
        issue(encodeI(isaPkg::OP_ADDI, 24, 0, 'h7abc));
        issue(encodeI(isaPkg::OP_SW, 24, 20, 4 + DMEM_DEPTH * 16));
        issue(encodeI(isaPkg::OP_LW, 25, 20, 4));
        issue(encodeI(isaPkg::OP_LW, 26, 0, 0));
        issue(encodeI(isaPkg::OP_LW, 27, 0, (DMEM_DEPTH - 1) * 4));
        issue(encodeI(isaPkg::OP_LW, 28, 0, -4));
        finishTest();
    endtask

    task automatic loadUseStall();
        startTest("load_use");
        issue(encodeI(isaPkg::OP_LW, 3, 0, 8));
        issue(encodeR(isaPkg::FN_ADD, 4, 3, 3));
        issue(encodeI(isaPkg::OP_LW, 5, 0, 12));
        issue(encodeR(isaPkg::FN_SUB, 6, 1, 2));
        // store data through rt after a load
        issue(encodeI(isaPkg::OP_LW, 7, 0, 16));
        issue(encodeI(isaPkg::OP_SW, 7, 0, 40));
        issue(encodeI(isaPkg::OP_LW, 8, 0, 40));
        issue(encodeI(isaPkg::OP_ADDI, 9, 8, 1));
        issue(encodeI(isaPkg::OP_LW, 10, 0, 0));
        idle(1);
        issue(encodeR(isaPkg::FN_OR, 11, 10, 10));
        issue(encodeI(isaPkg::OP_LW, 12, 0, 4));
        issue(encodeI(isaPkg::OP_LW, 13, 12, 0));
        issue(encodeR(isaPkg::FN_SLT, 14, 13, 12));
        issue(encodeI(isaPkg::OP_LW, 0, 0, 4));
        issue(encodeR(isaPkg::FN_ADD, 15, 0, 0));
        finishTest();
    endtask

    function automatic logic [31:0] randomInstr();
        int kind;
        int rd;
        int rs;
        int rt;
        int imm;
        // few registers so hazards come often
        kind = int'($urandom % 8);
        rd   = int'($urandom % 8);
        rs   = int'($urandom % 8);
        rt   = int'($urandom % 8);
        imm  = int'($urandom % 65536);
        case (kind)
            0:       return encodeR(isaPkg::FN_ADD, rd, rs, rt);
            1:       return encodeR(isaPkg::FN_SUB, rd, rs, rt);
            2:       return encodeR(isaPkg::FN_AND, rd, rs, rt);
            3:       return encodeR(isaPkg::FN_OR, rd, rs, rt);
            4:       return encodeR(isaPkg::FN_SLT, rd, rs, rt);
            5:       return encodeI(isaPkg::OP_ADDI, rt, rs, imm);
            6:       return encodeI(isaPkg::OP_LW, rt, rs, imm);
            default: return encodeI(isaPkg::OP_SW, rt, rs, imm);
        endcase
    endfunction

    function automatic int randomGap();
        if ($urandom % 2 == 0) begin
            return 0;
        end
        return 1 + int'($urandom % MAX_GAP);
    endfunction

    task automatic randomStream();
        startTest("random");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            idle(randomGap());
            issue(randomInstr());
        end
        finishTest();
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b1;
        instr       = '0;
        instrValid  = 1'b0;
        testsRun    = 0;
        testsFailed = 0;
        resetErrors = 0;
        readyErrors = 0;
        stallErrors = 0;
        wbErrors    = 0;
        flowErrors  = 0;
        void'($urandom(SEED));
        startTest("reset");
        #1 reset_n = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        finishTest();
        rtypeForwarding();
        addiAndZero();
        memoryAliasing();
        loadUseStall();
        randomStream();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errorTotal());
        if (testsFailed == 0 && errorTotal() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // bound on the whole run from the instruction budget
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the pipeline stopped making progress", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mipsPipe.f */
isaPkg.sv
pipePkg.sv
registerFile.sv
hazardForwardUnit.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsPipe.sv
tb_mipsPipe.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mipsPipe \
    -f mipsPipe.f -o simv > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
